// ==== rtl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and pc width.
`define CPU_XLEN          32

// architectural register file.
`define CPU_REG_ADDR_W    5
`define CPU_NUM_REGS      32

// pc of the first instruction after reset.
`define CPU_RESET_PC      0

// pc increment per accepted instruction.
`define CPU_PC_STEP       4

// width of the retired instruction counter.
`define CPU_RETIRE_CNT_W  16

`endif

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    // major opcodes executed by the core.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // alu operations.
    // pass_b forwards operand b, used by lui and by no-write instructions.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module instr_decode (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       instr_valid,
    input  logic [31:0]                instr,
    output logic                       dec_valid,
    output logic [`CPU_XLEN-1:0]       dec_pc,
    output logic [`CPU_REG_ADDR_W-1:0] dec_rs1,
    output logic [`CPU_REG_ADDR_W-1:0] dec_rs2,
    output logic [`CPU_REG_ADDR_W-1:0] dec_rd,
    output logic [`CPU_XLEN-1:0]       dec_imm,
    output logic                       dec_use_imm,
    output cpu_pkg::alu_op_e           dec_alu_op,
    output logic                       dec_we
);

    localparam logic [`CPU_XLEN-1:0] RESET_PC = `CPU_RESET_PC;
    localparam logic [`CPU_XLEN-1:0] PC_STEP  = `CPU_PC_STEP;

    cpu_pkg::opcode_e             opcode;
    logic [2:0]                   funct3;
    logic                         funct7_b5;
    logic [`CPU_REG_ADDR_W-1:0]   rd_field;
    cpu_pkg::alu_op_e             alu_op_nxt;
    logic [`CPU_XLEN-1:0]         imm_nxt;
    logic                         use_imm_nxt;
    logic                         supported;
    logic [`CPU_XLEN-1:0]         pc_cnt;

    // funct3 to alu operation, shared by reg-reg and reg-imm forms.
    // alt is funct7 bit 5; it selects sub only for the reg-reg form.
    function automatic cpu_pkg::alu_op_e map_funct3(input logic [2:0] f3,
                                                    input logic       alt,
                                                    input logic       is_reg);
        cpu_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  op = cpu_pkg::ALU_SLL;
            3'b010:  op = cpu_pkg::ALU_SLT;
            3'b011:  op = cpu_pkg::ALU_SLTU;
            3'b100:  op = cpu_pkg::ALU_XOR;
            3'b101:  op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  op = cpu_pkg::ALU_OR;
            default: op = cpu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd_field  = instr[11:7];

    always_comb begin
        alu_op_nxt  = cpu_pkg::ALU_PASS_B;
        imm_nxt     = '0;
        use_imm_nxt = 1'b1;
        supported   = 1'b0;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                supported   = 1'b1;
                use_imm_nxt = 1'b0;
                alu_op_nxt  = map_funct3(funct3, funct7_b5, 1'b1);
            end
            cpu_pkg::OPC_OP_IMM: begin
                supported  = 1'b1;
                alu_op_nxt = map_funct3(funct3, funct7_b5, 1'b0);
                // shifts take the 5-bit shamt, the rest a sign-extended imm.
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_nxt = {{(`CPU_XLEN-5){1'b0}}, instr[24:20]};
                end else begin
                    imm_nxt = {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};
                end
            end
            cpu_pkg::OPC_LUI: begin
                supported = 1'b1;
                imm_nxt   = {instr[31:12], 12'b0};
            end
            default: begin
                // anything else retires without a write.
                supported = 1'b0;
            end
        endcase
    end

    // next pc, one step per accepted instruction.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_cnt <= RESET_PC;
        end else if (instr_valid) begin
            pc_cnt <= pc_cnt + PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
            dec_we    <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
            dec_we    <= instr_valid && supported && (rd_field != '0);
        end
    end

    // decoded payload.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_pc      <= pc_cnt;
            dec_rs1     <= instr[19:15];
            dec_rs2     <= instr[24:20];
            dec_rd      <= rd_field;
            dec_imm     <= imm_nxt;
            dec_use_imm <= use_imm_nxt;
            dec_alu_op  <= alu_op_nxt;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr_b,
    output logic [`CPU_XLEN-1:0]       rd_data_a,
    output logic [`CPU_XLEN-1:0]       rd_data_b,
    input  logic                       wr_en,
    input  logic [`CPU_REG_ADDR_W-1:0] wr_addr,
    input  logic [`CPU_XLEN-1:0]       wr_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];

    // x0 is never written, the decoder drops those writes.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational read ports.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== rtl/alu_exec.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu_exec (
    input  logic [`CPU_XLEN-1:0] rs1_data,
    input  logic [`CPU_XLEN-1:0] rs2_data,
    input  logic [`CPU_XLEN-1:0] imm,
    input  logic                 use_imm,
    input  cpu_pkg::alu_op_e     alu_op,
    output logic [`CPU_XLEN-1:0] alu_result
);

    logic [`CPU_XLEN-1:0] op_b;
    logic [4:0]           shamt;
    logic                 lt_s;
    logic                 lt_u;

    // operand b from the immediate or rs2.
    assign op_b  = use_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    assign lt_s = $signed(rs1_data) < $signed(op_b);
    assign lt_u = rs1_data < op_b;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:    alu_result = rs1_data + op_b;
            cpu_pkg::ALU_SUB:    alu_result = rs1_data - op_b;
            cpu_pkg::ALU_AND:    alu_result = rs1_data & op_b;
            cpu_pkg::ALU_OR:     alu_result = rs1_data | op_b;
            cpu_pkg::ALU_XOR:    alu_result = rs1_data ^ op_b;
            cpu_pkg::ALU_SLL:    alu_result = rs1_data << shamt;
            cpu_pkg::ALU_SRL:    alu_result = rs1_data >> shamt;
            cpu_pkg::ALU_SRA:    alu_result = $unsigned($signed(rs1_data) >>> shamt);
            cpu_pkg::ALU_SLT:    alu_result = {{(`CPU_XLEN-1){1'b0}}, lt_s};
            cpu_pkg::ALU_SLTU:   alu_result = {{(`CPU_XLEN-1){1'b0}}, lt_u};
            cpu_pkg::ALU_PASS_B: alu_result = op_b;
            default:             alu_result = op_b;
        endcase
    end

endmodule

// ==== rtl/retire_stage.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module retire_stage (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         dec_valid,
    input  logic                         dec_we,
    input  logic [`CPU_REG_ADDR_W-1:0]   dec_rd,
    input  logic [`CPU_XLEN-1:0]         dec_pc,
    input  logic [`CPU_XLEN-1:0]         alu_result,
    output logic                         wr_en,
    output logic [`CPU_REG_ADDR_W-1:0]   wr_addr,
    output logic [`CPU_XLEN-1:0]         wr_data,
    output logic                         retire_valid,
    output logic                         retire_we,
    output logic [`CPU_XLEN-1:0]         retire_pc,
    output logic [`CPU_REG_ADDR_W-1:0]   retire_rd,
    output logic [`CPU_XLEN-1:0]         retire_data,
    output logic [`CPU_RETIRE_CNT_W-1:0] retire_count
);

    // register file write lands on the same edge as the retire record.
    assign wr_en   = dec_valid && dec_we;
    assign wr_addr = dec_rd;
    assign wr_data = alu_result;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
            retire_count <= '0;
        end else begin
            retire_valid <= dec_valid;
            retire_we    <= wr_en;
            // wraps at the counter width.
            if (dec_valid) begin
                retire_count <= retire_count + 1'b1;
            end
        end
    end

    // retire record payload.
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            retire_pc   <= dec_pc;
            retire_rd   <= dec_rd;
            retire_data <= alu_result;
        end
    end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    output logic                         retire_valid,
    output logic                         retire_we,
    output logic [`CPU_XLEN-1:0]         retire_pc,
    output logic [`CPU_REG_ADDR_W-1:0]   retire_rd,
    output logic [`CPU_XLEN-1:0]         retire_data,
    output logic [`CPU_RETIRE_CNT_W-1:0] retire_count
);

    // decode stage outputs.
    logic                       dec_valid;
    logic [`CPU_XLEN-1:0]       dec_pc;
    logic [`CPU_REG_ADDR_W-1:0] dec_rs1;
    logic [`CPU_REG_ADDR_W-1:0] dec_rs2;
    logic [`CPU_REG_ADDR_W-1:0] dec_rd;
    logic [`CPU_XLEN-1:0]       dec_imm;
    logic                       dec_use_imm;
    cpu_pkg::alu_op_e           dec_alu_op;
    logic                       dec_we;

    // operands and result.
    logic [`CPU_XLEN-1:0]       rs1_data;
    logic [`CPU_XLEN-1:0]       rs2_data;
    logic [`CPU_XLEN-1:0]       alu_result;

    // register file write port.
    logic                       wr_en;
    logic [`CPU_REG_ADDR_W-1:0] wr_addr;
    logic [`CPU_XLEN-1:0]       wr_data;

    instr_decode u_instr_decode (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_use_imm (dec_use_imm),
        .dec_alu_op  (dec_alu_op),
        .dec_we      (dec_we)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rstn      (rstn),
        .rd_addr_a (dec_rs1),
        .rd_addr_b (dec_rs2),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu_exec u_alu_exec (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (dec_imm),
        .use_imm    (dec_use_imm),
        .alu_op     (dec_alu_op),
        .alu_result (alu_result)
    );

    retire_stage u_retire_stage (
        .clk          (clk),
        .rstn         (rstn),
        .dec_valid    (dec_valid),
        .dec_we       (dec_we),
        .dec_rd       (dec_rd),
        .dec_pc       (dec_pc),
        .alu_result   (alu_result),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_count (retire_count)
    );

endmodule

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu;

    localparam int CLK_NS    = 10;
    localparam int MAX_GAP   = 3;
    localparam int NUM_INSTR = 240;
    // every instruction takes at most MAX_GAP + 1 cycles, plus drains and reset.
    localparam int WATCHDOG_NS = NUM_INSTR * (MAX_GAP + 1) * CLK_NS + 2000;

    localparam logic [31:0] RESET_PC = `CPU_RESET_PC;
    localparam logic [31:0] PC_STEP  = `CPU_PC_STEP;

    // rv32i major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic                         clk;
    logic                         rstn;
    logic                         instr_valid;
    logic [31:0]                  instr;
    logic                         retire_valid;
    logic                         retire_we;
    logic [`CPU_XLEN-1:0]         retire_pc;
    logic [`CPU_REG_ADDR_W-1:0]   retire_rd;
    logic [`CPU_XLEN-1:0]         retire_data;
    logic [`CPU_RETIRE_CNT_W-1:0] retire_count;

    // reference model state.
    logic [31:0]                  mregs [32];
    logic [31:0]                  mpc;
    logic [`CPU_RETIRE_CNT_W-1:0] mcount;
    int                           edge_cnt;
    int                           fail_count;
    integer                       seed;
    string                        test_name;

    // expected retire records, oldest first.
    int          exp_due[$];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    logic        exp_we[$];
    logic        exp_known[$];

    cpu_top DUT (
        .clk          (clk),
        .rstn         (rstn),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_count (retire_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout: the tests did not finish in the expected time");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_count++;
            abort_run($sformatf("[FAIL] %s: %s expected 0x%08h actual 0x%08h",
                                test_name, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, OPC_LUI};
    endfunction

    // isa model of one instruction; queues the record it should retire.
    task automatic model_step(input logic [31:0] w, input int due);
        logic [6:0]         opc;
        logic [4:0]         rd;
        logic [2:0]         f3;
        logic               alt;
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic [31:0]        res;
        logic               known;
        opc   = w[6:0];
        rd    = w[11:7];
        f3    = w[14:12];
        alt   = w[30];
        a     = mregs[w[19:15]];
        sa    = a;
        res   = '0;
        known = 1'b1;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            b = (opc == OPC_OP) ? mregs[w[24:20]] : {{20{w[31]}}, w[31:20]};
            case (f3)
                3'd0: res = (alt && opc == OPC_OP) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (alt) begin
                        res = sa >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else if (opc == OPC_LUI) begin
            res = {w[31:12], 12'h000};
        end else begin
            known = 1'b0;
        end
        exp_due.push_back(due);
        exp_pc.push_back(mpc);
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        exp_we.push_back(known && rd != 5'd0);
        exp_known.push_back(known);
        if (known && rd != 5'd0) begin
            mregs[rd] = res;
        end
        mpc = mpc + PC_STEP;
    endtask

    // outputs are sampled at the falling edge, away from the driving edge.
    always @(negedge clk) begin
        if (rstn) begin
            if (exp_due.size() != 0 && exp_due[0] == edge_cnt) begin
                mcount = mcount + 1'b1;
                check("retire_valid", 32'd1, retire_valid);
                check("retire_we", exp_we[0], retire_we);
                check("retire_pc", exp_pc[0], retire_pc);
                check("retire_rd", exp_rd[0], retire_rd);
                if (exp_known[0]) begin
                    check("retire_data", exp_data[0], retire_data);
                end
                void'(exp_due.pop_front());
                void'(exp_pc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_we.pop_front());
                void'(exp_known.pop_front());
            end else begin
                check("retire_valid while idle", 32'd0, retire_valid);
                check("retire_we while idle", 32'd0, retire_we);
            end
            check("retire_count", mcount, retire_count);
            if (instr_valid) begin
                model_step(instr, edge_cnt + 2);
            end
        end
        edge_cnt++;
    end

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // waits until every queued record has retired.
    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_due.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                abort_run("a retire record never appeared after the last instruction");
            end
        end
        @(negedge clk);
    endtask

    task automatic test_reset();
        test_name = "test_reset";
        idle(4);
        @(negedge clk);
        check("retire_valid", 32'd0, retire_valid);
        check("retire_we", 32'd0, retire_we);
        check("retire_count", 32'd0, retire_count);
        issue(i_type(12'd1, 5'd0, 3'd0, 5'd1));
        drain();
        check("first retire_pc", RESET_PC, retire_pc);
    endtask

    task automatic test_reg_ops();
        test_name = "test_reg_ops";
        issue(i_type(12'd100, 5'd0, 3'd0, 5'd1));
        issue(i_type(12'hffd, 5'd0, 3'd0, 5'd2));
        issue(i_type(12'h7ff, 5'd0, 3'd0, 5'd3));
        issue(i_type(12'd5, 5'd0, 3'd0, 5'd4));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
        issue(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd6));
        issue(r_type(7'h00, 5'd1, 5'd3, 3'd7, 5'd7));
        issue(r_type(7'h00, 5'd1, 5'd3, 3'd6, 5'd8));
        issue(r_type(7'h00, 5'd2, 5'd3, 3'd4, 5'd9));
        issue(r_type(7'h00, 5'd4, 5'd1, 3'd1, 5'd10));
        issue(r_type(7'h00, 5'd4, 5'd2, 3'd5, 5'd11));
        issue(r_type(7'h20, 5'd4, 5'd2, 3'd5, 5'd12));
        issue(r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd13));
        issue(r_type(7'h00, 5'd1, 5'd2, 3'd3, 5'd14));
        drain();
    endtask

    // each instruction reads the rd written by the one before.
    task automatic test_dependent_chain();
        test_name = "test_dependent_chain";
        issue(i_type(12'd3, 5'd0, 3'd0, 5'd20));
        issue(r_type(7'h00, 5'd20, 5'd20, 3'd0, 5'd21));
        issue(r_type(7'h20, 5'd20, 5'd21, 3'd0, 5'd22));
        issue(r_type(7'h00, 5'd20, 5'd22, 3'd1, 5'd23));
        issue(r_type(7'h00, 5'd22, 5'd23, 3'd4, 5'd24));
        issue(r_type(7'h20, 5'd24, 5'd0, 3'd0, 5'd25));
        issue(r_type(7'h20, 5'd20, 5'd25, 3'd5, 5'd26));
        issue(r_type(7'h00, 5'd26, 5'd24, 3'd3, 5'd27));
        drain();
    endtask

    task automatic test_imm_and_lui();
        test_name = "test_imm_and_lui";
        issue(i_type(12'hfff, 5'd0, 3'd0, 5'd1));
        issue(i_type(12'h800, 5'd0, 3'd0, 5'd2));
        issue(i_type(12'hffb, 5'd2, 3'd2, 5'd3));
        issue(i_type(12'hfff, 5'd1, 3'd3, 5'd4));
        issue(i_type(12'hfff, 5'd2, 3'd4, 5'd5));
        issue(i_type(12'h0f0, 5'd1, 3'd7, 5'd6));
        issue(i_type(12'h123, 5'd2, 3'd6, 5'd7));
        issue(i_type({7'h00, 5'd31}, 5'd1, 3'd1, 5'd8));
        issue(i_type({7'h00, 5'd4}, 5'd1, 3'd5, 5'd9));
        issue(i_type({7'h20, 5'd7}, 5'd2, 3'd5, 5'd10));
        issue(u_type(20'h80000, 5'd11));
        issue(u_type(20'hfffff, 5'd12));
        drain();
    endtask

    task automatic test_nowrite();
        test_name = "test_nowrite";
        issue(i_type(12'd5, 5'd1, 3'd0, 5'd0));
        issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));
        drain();
        check("x0 read", 32'd0, retire_data);
        // sw x1, 8(x2) and jal x3 must leave x8 and x3 untouched.
        issue({7'h00, 5'd1, 5'd2, 3'b010, 5'd8, OPC_STORE});
        issue({20'h00010, 5'd3, OPC_JAL});
        issue(r_type(7'h00, 5'd3, 5'd8, 3'd0, 5'd9));
        drain();
    endtask

    task automatic make_random_instr(output logic [31:0] w);
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        kind  = $unsigned($random(seed)) % 20;
        rd    = $random(seed);
        rs1   = $random(seed);
        rs2   = $random(seed);
        imm   = $random(seed);
        upper = $random(seed);
        case (kind)
            0: w = r_type(7'h00, rs2, rs1, 3'd0, rd);
            1: w = r_type(7'h20, rs2, rs1, 3'd0, rd);
            2: w = r_type(7'h00, rs2, rs1, 3'd1, rd);
            3: w = r_type(7'h00, rs2, rs1, 3'd2, rd);
            4: w = r_type(7'h00, rs2, rs1, 3'd3, rd);
            5: w = r_type(7'h00, rs2, rs1, 3'd4, rd);
            6: w = r_type(7'h00, rs2, rs1, 3'd5, rd);
            7: w = r_type(7'h20, rs2, rs1, 3'd5, rd);
            8: w = r_type(7'h00, rs2, rs1, 3'd6, rd);
            9: w = r_type(7'h00, rs2, rs1, 3'd7, rd);
            10: w = i_type(imm, rs1, 3'd0, rd);
            11: w = i_type(imm, rs1, 3'd2, rd);
            12: w = i_type(imm, rs1, 3'd3, rd);
            13: w = i_type(imm, rs1, 3'd4, rd);
            14: w = i_type(imm, rs1, 3'd6, rd);
            15: w = i_type(imm, rs1, 3'd7, rd);
            16: w = i_type({7'h00, rs2}, rs1, 3'd1, rd);
            17: w = i_type({7'h00, rs2}, rs1, 3'd5, rd);
            18: w = i_type({7'h20, rs2}, rs1, 3'd5, rd);
            default: w = u_type(upper, rd);
        endcase
    endtask

    task automatic test_random_stream();
        logic [31:0] w;
        int          gap;
        test_name = "test_random_stream";
        for (int i = 0; i < 200; i++) begin
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            idle(gap);
            make_random_instr(w);
            issue(w);
        end
        drain();
    endtask

    initial begin
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'h845d;
        mpc         = RESET_PC;
        mcount      = '0;
        edge_cnt    = 0;
        fail_count  = 0;
        test_name   = "reset";
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_reg_ops();
        test_dependent_chain();
        test_imm_and_lui();
        test_nowrite();
        test_random_stream();
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("one or more checks did not match");
        end
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/retire_stage.sv
rtl/cpu_top.sv
test/tb_cpu.sv
